// File: tm1638_pkg.sv
package tm1638_pkg;

    // ==================================================
    // Frame and byte sequencing
    // ==================================================
    typedef enum logic [4:0] {
        PH_IDLE,
        PH_DATA_CMD,
        PH_ADDR_CMD,
        PH_SEG,      // Segment byte of current digit
        PH_LAMP,     // Lamp byte of current digit
        PH_PWR_CMD,
        PH_KEY_CMD,
        PH_KEY       // Key bytes read back on MISO
    } frame_phase_e;

    typedef logic [3:0] bit_cnt_t;

    // Byte steps, one per en_ck tick
    localparam bit_cnt_t BC_IDLE   = 4'd0;
    localparam bit_cnt_t BC_LOAD   = 4'd1;
    localparam bit_cnt_t BC_BIT0   = 4'd2;
    localparam bit_cnt_t BC_BIT4   = 4'd6;
    localparam bit_cnt_t BC_BIT6   = 4'd8;
    localparam bit_cnt_t BC_BIT7   = 4'd9;
    localparam bit_cnt_t BC_FINISH = 4'd10;

    // ==================================================
    // TM1638 commands
    // ==================================================
    localparam logic [7:0] CMD_DATA_WRITE = 8'h40; // Write, auto increment
    localparam logic [7:0] CMD_ADDR_0     = 8'hC0;
    localparam logic [7:0] CMD_DISPLAY_ON = 8'h8F; // Full brightness
    localparam logic [7:0] CMD_KEY_READ   = 8'h42;

    localparam int KEY_BYTES = 4;

endpackage

// File: disp_pkg.sv
package disp_pkg;

    localparam int DIGITS = 8;

    typedef logic [3:0] nibble_t;
    typedef logic [6:0] seg_t;       // gfedcba
    typedef logic [2:0] digit_idx_t;
    typedef logic [7:0] key_vec_t;

    // Hex digit to seven segments, a in bit 0
    function automatic seg_t seg_encode(nibble_t nib);
        case (nib)
            4'h0: seg_encode = 7'b0111111;
            4'h1: seg_encode = 7'b0000110;
            4'h2: seg_encode = 7'b1011011;
            4'h3: seg_encode = 7'b1001111;
            4'h4: seg_encode = 7'b1100110;
            4'h5: seg_encode = 7'b1101101;
            4'h6: seg_encode = 7'b1111101;
            4'h7: seg_encode = 7'b0100111; // With f segment lit
            4'h8: seg_encode = 7'b1111111;
            4'h9: seg_encode = 7'b1101111;
            4'hA: seg_encode = 7'b1110111;
            4'hB: seg_encode = 7'b1111100; // Lower case b
            4'hC: seg_encode = 7'b0111001;
            4'hD: seg_encode = 7'b1011110; // Lower case d
            4'hE: seg_encode = 7'b1111001;
            default: seg_encode = 7'b1110001; // F
        endcase
    endfunction

endpackage

// File: tm1638_seq_if.sv
// Sequencer timing and state, shared by the data path
interface tm1638_seq_if;

    logic                     en_ck;     // Byte step strobe, SCLK fall
    logic                     en_sample; // One clock after SCLK rise
    tm1638_pkg::frame_phase_e phase;
    tm1638_pkg::bit_cnt_t     bit_cnt;
    disp_pkg::digit_idx_t     digit;
    logic [1:0]               key_byte;

    modport seq (
        output en_ck, en_sample, phase, bit_cnt, digit, key_byte
    );

    modport buf_in (
        input en_ck, phase, digit
    );

    modport sh_in (
        input en_ck, en_sample, phase, bit_cnt, key_byte
    );

endinterface

// File: sclk_timer.sv
module sclk_timer #(
    parameter int FCK_HZ  = 50_000_000,
    parameter int SCLK_HZ = 1_000_000,
    parameter int FPS     = 250
) (
    input  logic CK_i,
    input  logic XARST_i,
    output logic en_sclk_o,
    output logic en_xsclk_o,
    output logic en_sample_o,
    output logic frame_req_o
);

    localparam int HALF_DIV    = (FCK_HZ + 2 * SCLK_HZ - 1) / (2 * SCLK_HZ); // Rounded up
    localparam int HDIV_W      = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
    localparam int FRAME_TICKS = FCK_HZ / (2 * HALF_DIV * FPS); // en_ck ticks per frame
    localparam int FCNT_W      = $clog2(FRAME_TICKS);

    logic [HDIV_W-1:0] hdiv_q;
    logic              tog_q;     // Selects SCLK rise or fall
    logic              hdiv_cy;
    logic [FCNT_W-1:0] fcnt_q;
    logic              fcnt_cy;

    // A frame must fit between two requests
    if (FRAME_TICKS < 300) begin : g_rate_check
        $error("sclk_timer: FRAME_TICKS %0d below one full frame", FRAME_TICKS);
    end

    assign hdiv_cy = (hdiv_q == HDIV_W'(HALF_DIV - 1));
    assign fcnt_cy = (fcnt_q == FCNT_W'(FRAME_TICKS - 1));

    // ==================================================
    // Half-period divider
    // ==================================================
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            hdiv_q      <= '0;
            tog_q       <= 1'b0;
            en_sclk_o   <= 1'b0;
            en_xsclk_o  <= 1'b0;
            en_sample_o <= 1'b0;
        end else begin
            en_sclk_o   <= hdiv_cy & ~tog_q;
            en_xsclk_o  <= hdiv_cy & tog_q;
            en_sample_o <= en_sclk_o;        // MISO settled after SCLK rise
            if (hdiv_cy) begin
                hdiv_q <= '0;
                tog_q  <= ~tog_q;
            end else begin
                hdiv_q <= hdiv_q + 1'b1;
            end
        end
    end

    // Cyclic frame request, one en_ck period long
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            fcnt_q      <= '0;
            frame_req_o <= 1'b0;
        end else if (en_xsclk_o) begin
            frame_req_o <= fcnt_cy;
            fcnt_q      <= fcnt_cy ? '0 : fcnt_q + 1'b1;
        end
    end

    // No SCLK fall strobe together with or within half a period after a rise strobe
    a_strobes_apart: assert property (@(posedge CK_i) disable iff (!XARST_i)
        en_sclk_o |-> !en_xsclk_o [*HALF_DIV]);

endmodule

// File: frame_sequencer.sv
module frame_sequencer (
    input  logic       CK_i,
    input  logic       XARST_i,
    input  logic       en_sclk_i,
    input  logic       en_xsclk_i,
    input  logic       en_sample_i,
    input  logic       frame_req_i,
    tm1638_seq_if.seq  seq,
    output logic       ss_o,
    output logic       sclk_o,
    output logic       mosi_oe_o
);

    tm1638_pkg::frame_phase_e phase_q;
    tm1638_pkg::bit_cnt_t     bit_cnt_q;
    disp_pkg::digit_idx_t     digit_q;
    logic [1:0]               key_byte_q;
    logic                     last_digit;
    logic                     last_key;
    logic                     wr_phase;  // Byte driven on MOSI
    logic                     ss_open;   // Phase starting an SS window
    logic                     ss_close;  // Phase ending an SS window

    assign last_digit = (digit_q == disp_pkg::digit_idx_t'(disp_pkg::DIGITS - 1));
    assign last_key   = (key_byte_q == 2'(tm1638_pkg::KEY_BYTES - 1));
    assign wr_phase   = (phase_q != tm1638_pkg::PH_IDLE) && (phase_q != tm1638_pkg::PH_KEY);
    assign ss_open    = (phase_q == tm1638_pkg::PH_DATA_CMD) || (phase_q == tm1638_pkg::PH_ADDR_CMD)
                     || (phase_q == tm1638_pkg::PH_PWR_CMD) || (phase_q == tm1638_pkg::PH_KEY_CMD);
    assign ss_close   = (phase_q == tm1638_pkg::PH_DATA_CMD) || (phase_q == tm1638_pkg::PH_PWR_CMD)
                     || (phase_q == tm1638_pkg::PH_LAMP && last_digit)
                     || (phase_q == tm1638_pkg::PH_KEY && last_key);

    // ==================================================
    // Byte and frame state machines
    // ==================================================
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            bit_cnt_q <= tm1638_pkg::BC_IDLE;
        end else if (en_xsclk_i) begin
            if (frame_req_i) begin
                bit_cnt_q <= tm1638_pkg::BC_LOAD;  // Restart aborts any byte
            end else if (bit_cnt_q >= tm1638_pkg::BC_FINISH) begin
                bit_cnt_q <= tm1638_pkg::BC_IDLE;
            end else if (bit_cnt_q != tm1638_pkg::BC_IDLE || phase_q != tm1638_pkg::PH_IDLE) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            phase_q    <= tm1638_pkg::PH_IDLE;
            digit_q    <= '0;
            key_byte_q <= '0;
        end else if (en_xsclk_i) begin
            if (frame_req_i) begin
                phase_q    <= tm1638_pkg::PH_DATA_CMD;
                digit_q    <= '0;
                key_byte_q <= '0;
            end else if (bit_cnt_q == tm1638_pkg::BC_FINISH) begin
                case (phase_q)
                    tm1638_pkg::PH_DATA_CMD: phase_q <= tm1638_pkg::PH_ADDR_CMD;
                    tm1638_pkg::PH_ADDR_CMD: phase_q <= tm1638_pkg::PH_SEG;
                    tm1638_pkg::PH_SEG:      phase_q <= tm1638_pkg::PH_LAMP;
                    tm1638_pkg::PH_LAMP: begin
                        phase_q <= last_digit ? tm1638_pkg::PH_PWR_CMD : tm1638_pkg::PH_SEG;
                        digit_q <= digit_q + 1'b1;          // Wraps to 0 after last digit
                    end
                    tm1638_pkg::PH_PWR_CMD:  phase_q <= tm1638_pkg::PH_KEY_CMD;
                    tm1638_pkg::PH_KEY_CMD:  phase_q <= tm1638_pkg::PH_KEY;
                    tm1638_pkg::PH_KEY: begin
                        phase_q    <= last_key ? tm1638_pkg::PH_IDLE : tm1638_pkg::PH_KEY;
                        key_byte_q <= key_byte_q + 1'b1;
                    end
                    default:                 phase_q <= tm1638_pkg::PH_IDLE;
                endcase
            end
        end
    end

    // ==================================================
    // Bus control lines
    // ==================================================
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            ss_o      <= 1'b1;
            sclk_o    <= 1'b1;
            mosi_oe_o <= 1'b0;
        end else if (en_sclk_i) begin
            sclk_o <= 1'b1;                          // Data valid at rising edge
            if (bit_cnt_q == tm1638_pkg::BC_LOAD && ss_open)
                ss_o <= 1'b0;
        end else if (en_xsclk_i) begin
            if (phase_q != tm1638_pkg::PH_IDLE && bit_cnt_q >= tm1638_pkg::BC_LOAD
                    && bit_cnt_q <= tm1638_pkg::BC_BIT6)
                sclk_o <= 1'b0;
            if (frame_req_i || (bit_cnt_q == tm1638_pkg::BC_FINISH && ss_close))
                ss_o <= 1'b1;
            if (bit_cnt_q == tm1638_pkg::BC_BIT7)
                mosi_oe_o <= 1'b0;
            else if (bit_cnt_q == tm1638_pkg::BC_LOAD && wr_phase)
                mosi_oe_o <= 1'b1;
        end
    end

    assign seq.en_ck     = en_xsclk_i;
    assign seq.en_sample = en_sample_i;
    assign seq.phase     = phase_q;
    assign seq.bit_cnt   = bit_cnt_q;
    assign seq.digit     = digit_q;
    assign seq.key_byte  = key_byte_q;

    a_ss_idle: assert property (@(posedge CK_i) disable iff (!XARST_i)
        phase_q == tm1638_pkg::PH_IDLE |-> ss_o);
    a_oe_keys: assert property (@(posedge CK_i) disable iff (!XARST_i)
        phase_q == tm1638_pkg::PH_KEY |-> !mosi_oe_o);

endmodule

// File: display_buffer.sv
module display_buffer (
    input  logic                        CK_i,
    input  logic                        XARST_i,
    input  logic [31:0]                 bin_dat_i,
    input  disp_pkg::key_vec_t          sup_digits_i,
    input  logic [disp_pkg::DIGITS-1:0] dots_i,
    input  logic [disp_pkg::DIGITS-1:0] leds_i,
    input  logic                        frame_req_i,
    tm1638_seq_if.buf_in                seq,
    output logic [7:0]                  byte_data_o
);

    disp_pkg::nibble_t           nib_q [disp_pkg::DIGITS];
    disp_pkg::key_vec_t          sup_q;
    logic [disp_pkg::DIGITS-1:0] dots_q;
    logic [disp_pkg::DIGITS-1:0] leds_q;
    disp_pkg::nibble_t           cur_nib;
    disp_pkg::seg_t              cur_seg;

    // Snapshot of all display inputs for the whole frame
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            for (int i = 0; i < disp_pkg::DIGITS; i++)
                nib_q[i] <= '0;
            sup_q  <= '0;
            dots_q <= '0;
            leds_q <= '0;
        end else if (seq.en_ck && frame_req_i) begin
            for (int i = 0; i < disp_pkg::DIGITS; i++)
                nib_q[i] <= bin_dat_i[31 - 4 * i -: 4]; // Digit 0 is the top nibble
            sup_q  <= sup_digits_i;
            dots_q <= dots_i;
            leds_q <= leds_i;
        end
    end

    assign cur_nib = nib_q[seq.digit];
    assign cur_seg = sup_q[seq.digit] ? '0 : disp_pkg::seg_encode(cur_nib);

    // ==================================================
    // Byte for the current phase
    // ==================================================
    always_comb begin
        case (seq.phase)
            tm1638_pkg::PH_DATA_CMD: byte_data_o = tm1638_pkg::CMD_DATA_WRITE;
            tm1638_pkg::PH_ADDR_CMD: byte_data_o = tm1638_pkg::CMD_ADDR_0;
            tm1638_pkg::PH_SEG:      byte_data_o = {dots_q[seq.digit], cur_seg};
            tm1638_pkg::PH_LAMP:     byte_data_o = {7'd0, leds_q[seq.digit]};
            tm1638_pkg::PH_PWR_CMD:  byte_data_o = tm1638_pkg::CMD_DISPLAY_ON;
            tm1638_pkg::PH_KEY_CMD:  byte_data_o = tm1638_pkg::CMD_KEY_READ;
            default:                 byte_data_o = 8'h00; // Key bytes send nothing
        endcase
    end

endmodule

// File: serial_shifter.sv
module serial_shifter (
    input  logic               CK_i,
    input  logic               XARST_i,
    tm1638_seq_if.sh_in        seq,
    input  logic [7:0]         byte_data_i,
    input  logic               miso_i,
    output logic               mosi_o,
    output disp_pkg::key_vec_t keys_o
);

    logic [7:0] shift_q;
    logic [2:0] key_hi;   // Key bit taken at bit 0
    logic [2:0] key_lo;   // Key bit taken at bit 4

    // LSB first, empties to zero after bit 7
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            shift_q <= '0;
        end else if (seq.en_ck) begin
            if (seq.bit_cnt == tm1638_pkg::BC_LOAD)
                shift_q <= byte_data_i;
            else if (seq.bit_cnt >= tm1638_pkg::BC_BIT0 && seq.bit_cnt <= tm1638_pkg::BC_BIT7)
                shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign mosi_o = shift_q[0];

    // ==================================================
    // Key capture
    // ==================================================
    // Key byte k lands in bits 7-2k and 6-2k
    assign key_hi = {~seq.key_byte, 1'b1};
    assign key_lo = {~seq.key_byte, 1'b0};

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            keys_o <= '0;
        end else if (seq.en_sample && seq.phase == tm1638_pkg::PH_KEY) begin
            if (seq.bit_cnt == tm1638_pkg::BC_BIT0)
                keys_o[key_hi] <= miso_i;
            else if (seq.bit_cnt == tm1638_pkg::BC_BIT4)
                keys_o[key_lo] <= miso_i;
        end
    end

    a_mosi_quiet: assert property (@(posedge CK_i) disable iff (!XARST_i)
        (seq.bit_cnt == tm1638_pkg::BC_FINISH || seq.bit_cnt == tm1638_pkg::BC_IDLE)
            |-> !mosi_o);

endmodule

// File: tm1638_drv.sv
module tm1638_drv #(
    parameter int FCK_HZ  = 50_000_000,
    parameter int SCLK_HZ = 1_000_000,
    parameter int FPS     = 250
) (
    input  logic        CK_i,
    input  logic        XARST_i,
    input  logic [31:0] BIN_DAT_i,
    input  logic [7:0]  SUP_DIGITS_i,
    input  logic [7:0]  DOTS_i,
    input  logic [7:0]  LEDS_i,
    input  logic        MISO_i,
    output logic        FRAME_REQ_o,
    output logic        EN_CK_o,
    output logic        MOSI_o,
    output logic        MOSI_OE_o,
    output logic        SCLK_o,
    output logic        SS_o,
    output logic [7:0]  KEYS_o
);

    logic       en_sclk;
    logic       en_xsclk;
    logic       en_sample;
    logic       frame_req;
    logic [7:0] byte_data;

    tm1638_seq_if seq_if ();

    sclk_timer #(
        .FCK_HZ  (FCK_HZ),
        .SCLK_HZ (SCLK_HZ),
        .FPS     (FPS)
    ) u_sclk_timer (
        .CK_i (CK_i), .XARST_i (XARST_i),
        .en_sclk_o (en_sclk), .en_xsclk_o (en_xsclk),
        .en_sample_o (en_sample), .frame_req_o (frame_req)
    );

    frame_sequencer u_frame_sequencer (
        .CK_i (CK_i), .XARST_i (XARST_i),
        .en_sclk_i (en_sclk), .en_xsclk_i (en_xsclk),
        .en_sample_i (en_sample), .frame_req_i (frame_req),
        .seq (seq_if),
        .ss_o (SS_o), .sclk_o (SCLK_o), .mosi_oe_o (MOSI_OE_o)
    );

    display_buffer u_display_buffer (
        .CK_i (CK_i), .XARST_i (XARST_i),
        .bin_dat_i (BIN_DAT_i), .sup_digits_i (SUP_DIGITS_i),
        .dots_i (DOTS_i), .leds_i (LEDS_i), .frame_req_i (frame_req),
        .seq (seq_if), .byte_data_o (byte_data)
    );

    serial_shifter u_serial_shifter (
        .CK_i (CK_i), .XARST_i (XARST_i), .seq (seq_if),
        .byte_data_i (byte_data), .miso_i (MISO_i),
        .mosi_o (MOSI_o), .keys_o (KEYS_o)
    );

    assign FRAME_REQ_o = frame_req;
    assign EN_CK_o     = en_xsclk;   // Byte step strobe

endmodule

// File: tb_tm1638_model.sv
module tb_tm1638_model (
    input  logic        CK_i,
    input  logic        XARST_i,
    input  logic        SS_i,
    input  logic        SCLK_i,
    input  logic        MOSI_i,
    input  logic        FRAME_REQ_i,
    input  logic [31:0] key_word_i,  // Key byte k in bits 8k+7:8k
    output logic        miso_o,
    output logic        byte_vld_o,
    output logic [7:0]  byte_o,
    output logic [4:0]  pos_o,       // Byte index within the SS window
    output logic [2:0]  win_o,       // SS window index within the frame
    output logic        end_vld_o,
    output logic [2:0]  end_win_o,
    output logic [7:0]  end_bits_o,  // Bits clocked in the window just closed
    output logic        rd_drive_o   // Board owns the data line
);
    timeunit 1ns;
    timeprecision 1ps;

    logic       sclk_q;
    logic       ss_q;
    logic       req_q;
    logic       rd_mode_q;
    logic [7:0] sh_q;
    logic [7:0] bits_q;
    logic [4:0] rd_idx_q;
    logic [7:0] sh_nxt;

    assign sh_nxt = {MOSI_i, sh_q[7:1]};  // LSB first

    initial miso_o = 1'b0;

    // Bus lines sampled on the system clock, edges found against last sample
    always @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            sclk_q     <= 1'b1;
            ss_q       <= 1'b1;
            req_q      <= 1'b0;
            rd_mode_q  <= 1'b0;
            sh_q       <= '0;
            bits_q     <= '0;
            rd_idx_q   <= '0;
            miso_o     <= 1'b0;
            byte_vld_o <= 1'b0;
            byte_o     <= '0;
            pos_o      <= '0;
            win_o      <= '0;
            end_vld_o  <= 1'b0;
            end_win_o  <= '0;
            end_bits_o <= '0;
            rd_drive_o <= 1'b0;
        end else begin
            sclk_q     <= SCLK_i;
            ss_q       <= SS_i;
            req_q      <= FRAME_REQ_i;
            byte_vld_o <= 1'b0;
            end_vld_o  <= 1'b0;
            if (FRAME_REQ_i && !req_q)
                win_o <= '0;
            if (SS_i && !ss_q) begin                       // SS rise closes a window
                end_vld_o  <= 1'b1;
                end_win_o  <= win_o;
                end_bits_o <= bits_q;
                win_o      <= win_o + 1'b1;
                bits_q     <= '0;
                rd_mode_q  <= 1'b0;
                rd_idx_q   <= '0;
                rd_drive_o <= 1'b0;
                miso_o     <= 1'b0;
            end else if (!SS_i && SCLK_i && !sclk_q) begin // SCLK rise
                sh_q   <= sh_nxt;
                bits_q <= bits_q + 1'b1;
                if (bits_q[2:0] == 3'd7) begin
                    byte_vld_o <= 1'b1;
                    byte_o     <= sh_nxt;
                    pos_o      <= bits_q[7:3];
                    if (bits_q[7:3] == 5'd0 && sh_nxt == 8'h42)
                        rd_mode_q <= 1'b1;                 // Key bytes follow
                end
                if (rd_drive_o)
                    rd_idx_q <= rd_idx_q + 1'b1;
            end else if (!SS_i && !SCLK_i && sclk_q && rd_mode_q) begin
                rd_drive_o <= 1'b1;
                miso_o     <= key_word_i[rd_idx_q];       // Settles long before the rise
            end
        end
    end

endmodule

// File: tb_tm1638_drv.sv
module tb_tm1638_drv;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAMES     = 6;
    localparam int TESTS      = 6;
    localparam int REQ_PERIOD = 400 * 50;  // FRAME_TICKS times the en_ck period
    localparam int REQ_TMO    = 25_000;
    localparam int END_TMO    = 15_000;

    // Segments for 0 to F, a in bit 0
    localparam logic [6:0] SEG_TAB [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h27,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic        ck;
    logic        xarst;
    logic [31:0] bin_dat;
    logic [7:0]  sup_digits;
    logic [7:0]  dots;
    logic [7:0]  leds;
    logic        miso;
    logic        frame_req;
    logic        en_ck;
    logic        mosi;
    logic        mosi_oe;
    logic        sclk;
    logic        ss;
    logic [7:0]  keys;
    logic [31:0] key_word;
    logic        byte_vld;
    logic [7:0]  byte_val;
    logic [4:0]  byte_pos;
    logic [2:0]  win;
    logic        end_vld;
    logic [2:0]  end_win;
    logic [7:0]  end_bits;
    logic        rd_drive;

    logic  past_first_edge = 1'b0;
    logic  seen_req = 1'b0;
    logic  req_q = 1'b0;
    int    cyc = 0;
    int    last_rise = 0;
    int    prev_rise = 0;
    bit    timed_out = 1'b0;
    int    err_cnt [TESTS] = '{default: 0};
    bit    done [TESTS] = '{default: 1'b0};
    string test_name [TESTS] = '{"reset_state", "command_bytes", "segment_bytes",
                                 "lamp_bytes", "keys", "frame_rate"};

    tm1638_drv #(
        .FCK_HZ  (50_000_000),
        .SCLK_HZ (1_000_000),
        .FPS     (2500)
    ) UUT (
        .CK_i (ck), .XARST_i (xarst),
        .BIN_DAT_i (bin_dat), .SUP_DIGITS_i (sup_digits),
        .DOTS_i (dots), .LEDS_i (leds), .MISO_i (miso),
        .FRAME_REQ_o (frame_req), .EN_CK_o (en_ck), .MOSI_o (mosi),
        .MOSI_OE_o (mosi_oe), .SCLK_o (sclk), .SS_o (ss), .KEYS_o (keys)
    );

    tb_tm1638_model board (
        .CK_i (ck), .XARST_i (xarst), .SS_i (ss), .SCLK_i (sclk),
        .MOSI_i (mosi), .FRAME_REQ_i (frame_req), .key_word_i (key_word),
        .miso_o (miso), .byte_vld_o (byte_vld), .byte_o (byte_val),
        .pos_o (byte_pos), .win_o (win), .end_vld_o (end_vld),
        .end_win_o (end_win), .end_bits_o (end_bits), .rd_drive_o (rd_drive)
    );

    initial begin : clock_gen
        ck = 1'b0;
        forever #10 ck = ~ck;
    end

    always @(posedge ck) begin
        past_first_edge <= 1'b1;
        cyc             <= cyc + 1;
        req_q           <= frame_req;
        if (frame_req && !req_q) begin  // Frame request rise
            seen_req  <= 1'b1;
            prev_rise <= last_rise;
            last_rise <= cyc;
        end
    end

    // ==================================================
    // Expected values
    // ==================================================
    function automatic logic [7:0] exp_byte(logic [2:0] w, logic [4:0] pos);
        int         d;
        logic [3:0] nib;
        d   = (int'(pos) - 1) / 2;
        nib = bin_dat[31 - 4 * d -: 4];  // Digit 0 is the top nibble
        case (w)
            3'd0: return 8'h40;
            3'd1: begin
                if (pos == 5'd0)
                    return 8'hC0;
                if (pos[0])
                    return {dots[d], sup_digits[d] ? 7'h00 : SEG_TAB[nib]};
                return {7'h00, leds[d]};
            end
            3'd2: return 8'h8F;
            3'd3: return (pos == 5'd0) ? 8'h42 : 8'h00;  // MOSI idle on key bytes
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] exp_bits(logic [2:0] w);
        case (w)
            3'd0, 3'd2: return 8'd8;
            3'd1: return 8'd136;        // Address and sixteen display bytes
            3'd3: return 8'd40;
            default: return 8'd0;
        endcase
    endfunction

    function automatic logic [7:0] exp_keys(logic [31:0] kw);
        logic [7:0] k;
        for (int b = 0; b < 4; b++) begin
            k[7 - 2 * b] = kw[8 * b];
            k[6 - 2 * b] = kw[8 * b + 4];
        end
        return k;
    endfunction

    task automatic value_error(input int t, input logic [31:0] exp, input logic [31:0] act);
        err_cnt[t]++;
        $display("** Error %s expected %0h actual %0h", test_name[t], exp, act);
    endtask

    task automatic plain_error(input int t, input string what);
        err_cnt[t]++;
        $display("%s: %s", test_name[t], what);
    endtask

    task automatic finish_test(input int t);
        done[t] = 1'b1;
        $display("Test %s %s with %0d errors", test_name[t],
                 (err_cnt[t] == 0) ? "ok" : "bad", err_cnt[t]);
    endtask

    // ==================================================
    // Checks on the bus
    // ==================================================
    a_reset_state: assert property (@(posedge ck) past_first_edge && !seen_req
            |-> {ss, sclk, mosi_oe, mosi, keys} == 12'hC00)
        else value_error(0, 32'hC00, 32'($sampled({ss, sclk, mosi_oe, mosi, keys})));
    a_reset_strobes: assert property (@(posedge ck) past_first_edge && !xarst
            |-> !frame_req && !en_ck)
        else plain_error(0, "FRAME_REQ or EN_CK high during reset");

    a_cmd_bytes: assert property (@(posedge ck) disable iff (!xarst)
            byte_vld && !(win == 3'd1 && byte_pos != 5'd0)
            |-> byte_val == exp_byte(win, byte_pos))
        else value_error(1, exp_byte($sampled(win), $sampled(byte_pos)), $sampled(byte_val));
    a_window_len: assert property (@(posedge ck) disable iff (!xarst)
            end_vld |-> end_bits == exp_bits(end_win))
        else value_error(1, exp_bits($sampled(end_win)), $sampled(end_bits));
    a_oe_off: assert property (@(posedge ck) disable iff (!xarst) rd_drive |-> !mosi_oe)
        else plain_error(1, "MOSI_OE high while the board drives MISO");

    a_seg_bytes: assert property (@(posedge ck) disable iff (!xarst)
            byte_vld && win == 3'd1 && byte_pos[0]
            |-> byte_val == exp_byte(win, byte_pos))
        else value_error(2, exp_byte($sampled(win), $sampled(byte_pos)), $sampled(byte_val));
    a_lamp_bytes: assert property (@(posedge ck) disable iff (!xarst)
            byte_vld && win == 3'd1 && byte_pos != 5'd0 && !byte_pos[0]
            |-> byte_val == exp_byte(win, byte_pos))
        else value_error(3, exp_byte($sampled(win), $sampled(byte_pos)), $sampled(byte_val));

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic load_frame_inputs(input int f);
        if (f == 0) begin
            bin_dat    <= 32'h0123_4567;
            sup_digits <= 8'h00;
        end else if (f == 1) begin
            bin_dat    <= 32'h89AB_CDEF;
            sup_digits <= 8'h00;
        end else begin
            bin_dat    <= $urandom();
            sup_digits <= 8'($urandom());
        end
        dots     <= 8'($urandom());
        leds     <= 8'($urandom());
        key_word <= $urandom();       // Read back in the next frame
    endtask

    task automatic wait_frame_req(output bit ok);
        int n;
        n = 0;
        do begin
            @(posedge ck);
            n++;
        end while (!frame_req && n < REQ_TMO);
        ok = frame_req;
        if (!ok) begin
            timed_out = 1'b1;
            $display("Timeout: no frame request within %0d clocks", REQ_TMO);
        end
    endtask

    task automatic wait_frame_end(output bit ok);
        int n;
        n = 0;
        do begin
            @(posedge ck);
            n++;
        end while (!(win == 3'd4 && ss) && n < END_TMO);
        ok = (win == 3'd4 && ss);
        if (!ok) begin
            timed_out = 1'b1;
            $display("Timeout: frame did not close its four SS windows in %0d clocks", END_TMO);
        end
    endtask

    task automatic run_frames();
        logic [7:0] held;
        bit         ok;
        wait_frame_req(ok);
        if (!ok)
            return;
        finish_test(0);
        for (int f = 0; f < FRAMES; f++) begin
            wait_frame_end(ok);
            if (!ok)
                return;
            held = exp_keys(key_word);
            a_keys_read: assert (keys == held) else value_error(4, held, keys);
            if (f > 0) begin
                a_rate: assert (last_rise - prev_rise == REQ_PERIOD)
                    else value_error(5, REQ_PERIOD, last_rise - prev_rise);
            end
            load_frame_inputs(f + 1);
            wait_frame_req(ok);
            if (!ok)
                return;
            a_keys_held: assert (keys == held) else value_error(4, held, keys);
        end
        for (int t = 1; t < TESTS; t++)
            finish_test(t);
    endtask

    initial begin : stimulus
        int npass;
        void'($urandom(32'hb5eb));
        npass      = 0;
        xarst      = 1'b0;
        bin_dat    = '0;
        sup_digits = '0;
        dots       = '0;
        leds       = '0;
        key_word   = '0;
        repeat (16) @(posedge ck);
        xarst <= 1'b1;
        load_frame_inputs(0);
        run_frames();
        for (int t = 0; t < TESTS; t++) begin
            if (done[t] && err_cnt[t] == 0)
                npass++;
        end
        $display("Tests: %0d ok, %0d bad", npass, TESTS - npass);
        if (timed_out || npass != TESTS) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

// File: filelist.f
tm1638_pkg.sv
disp_pkg.sv
tm1638_seq_if.sv
sclk_timer.sv
frame_sequencer.sv
display_buffer.sv
serial_shifter.sv
tm1638_drv.sv
tb_tm1638_model.sv
tb_tm1638_drv.sv

// File: Bender.yml
package:
  name: tm1638_drv

sources:
  - files:
      - tm1638_pkg.sv
      - disp_pkg.sv
      - tm1638_seq_if.sv
      - sclk_timer.sv
      - frame_sequencer.sv
      - display_buffer.sv
      - serial_shifter.sv
      - tm1638_drv.sv
  - target: test
    files:
      - tb_tm1638_model.sv
      - tb_tm1638_drv.sv
